// ==== bench/tb_framing.sv ====
// Testbench tb_framing with clock, reset, bus and stream tasks, directed tests and watchdog
`include "framing_macros.svh"

module tb_framing;
  timeunit 1ns;
  timeprecision 100ps;
  import framing_pkg::*;

  localparam int TOTAL_LEN = 2 * 61 + 64 + 4 * 40 + 9 * 48;   // Bytes over all test frames
  localparam int WATCHDOG_CYCLES = TOTAL_LEN * 20 + 2000;

  logic                   clk_int;
  logic                   rst_int;
  logic                   ce_i;
  logic                   we_i;
  logic [7:0]             be_i;
  logic [`FRM_ADDR_W-1:0] addr_i;
  word_t                  wdata_i;
  word_t                  rdata_o;
  logic [7:0]             tx_data_o;
  logic                   tx_valid_o;
  logic                   tx_ready_i;
  logic                   tx_last_o;
  logic [7:0]             rx_data_i;
  logic                   rx_valid_i;
  logic                   rx_last_i;
  logic                   irq_o;

  int          value_errs;
  int          other_errs;
  int          seed;
  logic [47:0] station_mac;
  buf_idx_t    exp_prod;                     // Ring pointers as the bench predicts them
  buf_idx_t    exp_cons;
  logic [7:0]  sent_bytes [`FRM_MAX_LEN];    // Bytes of the last received frame

  framing_top i_dut (
    .clk_int    (clk_int),
    .rst_int    (rst_int),
    .ce_i       (ce_i),
    .we_i       (we_i),
    .be_i       (be_i),
    .addr_i     (addr_i),
    .wdata_i    (wdata_i),
    .rdata_o    (rdata_o),
    .tx_data_o  (tx_data_o),
    .tx_valid_o (tx_valid_o),
    .tx_ready_i (tx_ready_i),
    .tx_last_o  (tx_last_o),
    .rx_data_i  (rx_data_i),
    .rx_valid_i (rx_valid_i),
    .rx_last_i  (rx_last_i),
    .irq_o      (irq_o)
  );

  always #2 clk_int = ~clk_int;              // 4 ns period

  task automatic report_mismatch(input string test, input logic [63:0] exp_val,
                                 input logic [63:0] act_val);
    value_errs++;
    $display("ERR %s expected %h actual %h", test, exp_val, act_val);
  endtask

  task automatic report_failure(input string what);
    other_errs++;
    $display("%s", what);
  endtask

  function automatic logic [14:0] reg_addr(input int idx);
    return `FRM_REG_BASE + 15'(idx * 8);
  endfunction

  function automatic logic [14:0] tx_addr(input int word);
    return `FRM_TX_BASE + 15'(word * 8);
  endfunction

  function automatic logic [14:0] rx_addr(input int slot, input int word);
    return `FRM_RX_BASE + 15'((slot * `FRM_RX_BUF_WORDS + word) * 8);
  endfunction

  function automatic word_t ctrl_word(input logic irq_en, input logic promisc);
    return {irq_en, promisc, 46'b0, station_mac[47:32]};
  endfunction

  function automatic logic [7:0] tx_byte(input int i);
    return 8'((i * 37 + 11) ^ (i >> 3));
  endfunction

  function automatic logic [7:0] frame_byte(input logic [47:0] dest, input int i, input int tag);
    if (i < 6)
      return dest[8 * (5 - i) +: 8];         // Destination leads with its high byte first
    return 8'(i * 5 + tag * 29);
  endfunction

  task automatic bus_write(input logic [14:0] addr, input word_t data);
    @(posedge clk_int);
    ce_i    <= 1'b1;
    we_i    <= 1'b1;
    be_i    <= 8'hFF;
    addr_i  <= addr;
    wdata_i <= data;
    @(posedge clk_int);
    ce_i <= 1'b0;
    we_i <= 1'b0;
  endtask

  task automatic bus_read(input logic [14:0] addr, output word_t data);
    @(posedge clk_int);
    ce_i   <= 1'b1;
    we_i   <= 1'b0;
    addr_i <= addr;
    @(posedge clk_int);
    ce_i <= 1'b0;
    @(negedge clk_int);
    data = rdata_o;                          // Middle of the data phase
  endtask

  task automatic check_status(input string test);
    word_t rd;
    word_t exp_word;
    bus_read(reg_addr(RX_STATUS), rd);
    exp_word = word_t'({1'b0, exp_prod != exp_cons, exp_prod, exp_cons});
    if (rd !== exp_word)
      report_mismatch(test, exp_word, rd);
  endtask

  task automatic send_frame(input logic [47:0] dest, input int len, input int tag);
    for (int i = 0; i < len; i++)
    begin
      sent_bytes[i] = frame_byte(dest, i, tag);
      @(posedge clk_int);
      rx_valid_i <= 1'b1;
      rx_data_i  <= sent_bytes[i];
      rx_last_i  <= (i == len - 1);
    end
    @(posedge clk_int);
    rx_valid_i <= 1'b0;
    rx_last_i  <= 1'b0;
  endtask

  task automatic fill_tx_buffer(input int len);
    word_t data;
    for (int w = 0; w < (len + 7) / 8; w++)
    begin
      for (int b = 0; b < 8; b++)
        data[8 * b +: 8] = tx_byte(8 * w + b);   // Lane 0 goes out first
      bus_write(tx_addr(w), data);
    end
  endtask

  task automatic collect_tx(input string test, input int len, input bit stall);
    int cnt;
    bit done;
    cnt  = 0;
    done = 1'b0;
    while (!done)
    begin
      @(posedge clk_int);
      tx_ready_i <= stall ? 1'($random(seed)) : 1'b1;
      @(negedge clk_int);
      if (tx_valid_o && tx_ready_i)
      begin
        if (tx_data_o !== tx_byte(cnt))
          report_mismatch(test, tx_byte(cnt), tx_data_o);
        if (tx_last_o !== (cnt == len - 1))
          report_mismatch({test, " last"}, cnt == len - 1, tx_last_o);
        done = tx_last_o || (cnt == len - 1);
        cnt++;
      end
    end
    @(posedge clk_int);                      // Edge that takes the final byte
    tx_ready_i <= 1'b1;
  endtask

  task automatic wait_irq(input logic level, input string test);
    int n;
    n = 0;
    @(negedge clk_int);
    while (irq_o !== level && n < 8)
    begin
      @(negedge clk_int);
      n++;
    end
    if (irq_o !== level)
      report_mismatch(test, level, irq_o);
  endtask

  task automatic test_regs();
    word_t       rd;
    logic [47:0] def_mac;
    def_mac = `FRM_DEF_MAC;
    bus_read(reg_addr(MAC_LO), rd);
    if (rd !== {32'h0, def_mac[31:0]})
      report_mismatch("regs reset mac_lo", {32'h0, def_mac[31:0]}, rd);
    bus_read(reg_addr(MAC_HI_CTRL), rd);
    if (rd !== {48'h0, def_mac[47:32]})
      report_mismatch("regs reset mac_hi", {48'h0, def_mac[47:32]}, rd);
    bus_read(reg_addr(RX_STATUS), rd);
    if (rd !== 64'h0)
      report_mismatch("regs reset status", 64'h0, rd);
    station_mac = 48'h02A1B2C3D4E5;
    bus_write(reg_addr(MAC_LO), {32'h0, station_mac[31:0]});
    bus_write(reg_addr(MAC_HI_CTRL), ctrl_word(1'b1, 1'b1));
    bus_read(reg_addr(MAC_LO), rd);
    if (rd !== {32'h0, station_mac[31:0]})
      report_mismatch("regs mac_lo", {32'h0, station_mac[31:0]}, rd);
    bus_read(reg_addr(MAC_HI_CTRL), rd);
    if (rd !== ctrl_word(1'b1, 1'b1))
      report_mismatch("regs mac_hi ctrl on", ctrl_word(1'b1, 1'b1), rd);
    bus_write(reg_addr(MAC_HI_CTRL), ctrl_word(1'b0, 1'b0));
    bus_read(reg_addr(MAC_HI_CTRL), rd);
    if (rd !== ctrl_word(1'b0, 1'b0))
      report_mismatch("regs mac_hi ctrl off", ctrl_word(1'b0, 1'b0), rd);
  endtask

  task automatic test_tx();
    word_t rd;
    string name;
    fill_tx_buffer(61);
    for (int pass = 0; pass < 2; pass++)
    begin
      if (pass == 0)
        name = "tx ready high";
      else
        name = "tx backpressure";
      @(posedge clk_int);
      tx_ready_i <= 1'b0;                    // Hold the stream until busy is seen
      bus_write(reg_addr(TX_LEN), 64'd61);
      bus_read(reg_addr(RX_STATUS), rd);
      if (rd[9] !== 1'b1)
        report_mismatch({name, " busy during"}, 1'b1, rd[9]);
      collect_tx(name, 61, pass == 1);
      bus_read(reg_addr(RX_STATUS), rd);
      if (rd[9] !== 1'b0)
        report_mismatch({name, " busy after"}, 1'b0, rd[9]);
      if (tx_valid_o !== 1'b0)
        report_failure("tx_valid_o stayed high after the final byte");
    end
  endtask

  task automatic test_rx_accept();
    word_t rd;
    word_t exp_word;
    int    slot;
    slot = exp_prod[2:0];
    send_frame(station_mac, 64, 1);
    exp_prod = exp_prod + 1'b1;
    check_status("rx accept status");
    bus_read(reg_addr(RX_LEN0 + slot), rd);
    if (rd !== 64'd64)
      report_mismatch("rx accept length", 64'd64, rd);
    for (int w = 0; w < 8; w++)
    begin
      for (int b = 0; b < 8; b++)
        exp_word[8 * b +: 8] = sent_bytes[8 * w + b];
      bus_read(rx_addr(slot, w), rd);
      if (rd !== exp_word)
        report_mismatch("rx accept contents", exp_word, rd);
    end
  endtask

  task automatic test_filter();
    word_t rd;
    int    slot;
    send_frame(48'h021122334455, 40, 2);
    check_status("filter foreign unicast");
    slot = exp_prod[2:0];
    send_frame(48'hFFFFFFFFFFFF, 40, 3);
    exp_prod = exp_prod + 1'b1;
    check_status("filter broadcast");
    bus_read(reg_addr(RX_LEN0 + slot), rd);
    if (rd !== 64'd40)
      report_mismatch("filter broadcast length", 64'd40, rd);
    send_frame(48'h01005E0A0B0C, 40, 4);
    exp_prod = exp_prod + 1'b1;
    check_status("filter multicast");
    bus_write(reg_addr(MAC_HI_CTRL), ctrl_word(1'b0, 1'b1));
    send_frame(48'h021122334455, 40, 5);
    exp_prod = exp_prod + 1'b1;
    check_status("filter promiscuous");
    bus_write(reg_addr(MAC_HI_CTRL), ctrl_word(1'b0, 1'b0));
  endtask

  task automatic test_ring_irq();
    @(negedge clk_int);
    if (irq_o !== 1'b0)
      report_mismatch("ring irq disabled", 1'b0, irq_o);   // Unread frames wait with irq_en off
    exp_cons = exp_prod;                     // Start from an empty ring
    bus_write(reg_addr(RX_CONSUME), 64'(exp_cons));
    bus_write(reg_addr(MAC_HI_CTRL), ctrl_word(1'b1, 1'b0));
    check_status("ring empty");
    if (irq_o !== 1'b0)
      report_mismatch("ring irq while empty", 1'b0, irq_o);
    send_frame(station_mac, 48, 6);
    exp_prod = exp_prod + 1'b1;
    wait_irq(1'b1, "ring irq after accept");
    for (int i = 1; i < 9; i++)
    begin
      send_frame(station_mac, 48, 6 + i);
      if (i < 8)
        exp_prod = exp_prod + 1'b1;          // Ninth frame meets a full ring
    end
    check_status("ring full");
    exp_cons = exp_prod;
    bus_write(reg_addr(RX_CONSUME), 64'(exp_cons));
    check_status("ring drained");
    wait_irq(1'b0, "ring irq after drain");
  endtask

  initial
  begin
    clk_int     = 1'b0;
    rst_int     = 1'b1;
    ce_i        = 1'b0;
    we_i        = 1'b0;
    be_i        = 8'h00;
    addr_i      = '0;
    wdata_i     = '0;
    tx_ready_i  = 1'b0;
    rx_data_i   = 8'h00;
    rx_valid_i  = 1'b0;
    rx_last_i   = 1'b0;
    value_errs  = 0;
    other_errs  = 0;
    seed        = 57704;
    exp_prod    = '0;
    exp_cons    = '0;
    station_mac = `FRM_DEF_MAC;
    repeat (8) @(posedge clk_int);
    rst_int <= 1'b0;
    test_regs();
    test_tx();
    test_rx_accept();
    test_filter();
    test_ring_irq();
    repeat (4) @(posedge clk_int);
    $display("Value errors: %0d, other errors: %0d", value_errs, other_errs);
    if (value_errs + other_errs == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  // Bound on the run scaled by the bytes the tests move
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_int);
    report_failure("Watchdog expired before the tests completed");
    $display("Value errors: %0d, other errors: %0d", value_errs, other_errs);
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+include
logic/framing_pkg.sv
logic/buf_port_if.sv
logic/frame_ram.sv
logic/framing_regs.sv
logic/tx_framer.sv
logic/rx_framer.sv
logic/framing_top.sv
bench/tb_framing.sv

// ==== include/framing_macros.svh ====
// Buffer sizes, address widths, window bases and reset MAC address for the framing block
`ifndef FRAMING_MACROS_SVH
`define FRAMING_MACROS_SVH

`define FRM_ADDR_W       15                // Byte address on the load/store bus
`define FRM_TX_WORDS     256               // 2 KB transmit buffer
`define FRM_RX_BUFS      8                 // Receive ring entries
`define FRM_RX_BUF_WORDS 256               // 2 KB per receive buffer
`define FRM_MAX_LEN      2048              // Longest frame in bytes

`define FRM_TX_AW        8                 // Word address into the transmit RAM
`define FRM_RX_AW        11                // Buffer index and word offset into the receive RAM
`define FRM_REG_AW       4                 // Register word offset

// Window bases as byte addresses
`define FRM_REG_BASE     15'h0800
`define FRM_TX_BASE      15'h1000
`define FRM_RX_BASE      15'h4000

// First byte on the wire sits in bits 47:40
`define FRM_DEF_MAC      48'h230100890702

`endif

// ==== logic/buf_port_if.sv ====
// Interface buf_port_if for one RAM port with owner and ram modports
interface buf_port_if #(
  parameter int AW = 8                       // Word address width
) ();
  import framing_pkg::*;

  logic          en;                         // Access strobe, read or write
  logic [7:0]    we;                         // Byte lane write enables
  logic [AW-1:0] addr;
  word_t         wdata;
  word_t         rdata;                      // Valid the cycle after en

  modport owner (
    output en, we, addr, wdata,
    input  rdata
  );

  modport ram (
    input  en, we, addr, wdata,
    output rdata
  );

endinterface

// ==== logic/frame_ram.sv ====
// Module frame_ram holding a true two-port RAM of 64-bit words with byte write enables
module frame_ram #(
  parameter int DEPTH_WORDS = 256
) (
  input logic       clk_int,
  input logic       rst_int,
  buf_port_if.ram   port_a_i,
  buf_port_if.ram   port_b_i
);
  import framing_pkg::*;

  word_t mem [DEPTH_WORDS];

  // Port B is applied last and wins a same-cycle write to the same lane
  always_ff @(posedge clk_int)
  begin
    if (port_a_i.en)
    begin
      for (int b = 0; b < 8; b++)
      begin
        if (port_a_i.we[b])
          mem[port_a_i.addr][8*b +: 8] <= port_a_i.wdata[8*b +: 8];
      end
    end
    if (port_b_i.en)
    begin
      for (int b = 0; b < 8; b++)
      begin
        if (port_b_i.we[b])
          mem[port_b_i.addr][8*b +: 8] <= port_b_i.wdata[8*b +: 8];
      end
    end
  end

  // Registered read returns old contents on a write to the same word
  always_ff @(posedge clk_int)
  begin
    if (rst_int)
    begin
      port_a_i.rdata <= '0;
      port_b_i.rdata <= '0;
    end
    else
    begin
      if (port_a_i.en)
        port_a_i.rdata <= mem[port_a_i.addr];
      if (port_b_i.en)
        port_b_i.rdata <= mem[port_b_i.addr];
    end
  end

endmodule

// ==== logic/framing_pkg.sv ====
// Package framing_pkg with the word, length, ring pointer and register index types
`include "framing_macros.svh"

package framing_pkg;

  typedef logic [63:0] word_t;                         // Bus and RAM word

  typedef logic [$clog2(`FRM_MAX_LEN):0] len_t;        // Wide enough to hold FRM_MAX_LEN

  // One bit wider than the buffer index so that a full ring differs from an empty one
  typedef logic [$clog2(`FRM_RX_BUFS):0] buf_idx_t;

  typedef enum logic [`FRM_REG_AW-1:0] {
    MAC_LO      = 4'd0,
    MAC_HI_CTRL = 4'd1,                                // MAC 47:32, promiscuous, irq enable
    TX_LEN      = 4'd2,
    RX_STATUS   = 4'd3,
    RX_CONSUME  = 4'd4,
    RX_LEN0     = 4'd8,
    RX_LEN1     = 4'd9,
    RX_LEN2     = 4'd10,
    RX_LEN3     = 4'd11,
    RX_LEN4     = 4'd12,
    RX_LEN5     = 4'd13,
    RX_LEN6     = 4'd14,
    RX_LEN7     = 4'd15
  } reg_idx_e;

endpackage

// ==== logic/framing_regs.sv ====
// Module framing_regs with the bus decoder, control and status registers, read mux and interrupt
`include "framing_macros.svh"

module framing_regs (
  input  logic                    clk_int,
  input  logic                    rst_int,
  input  logic                    ce_i,
  input  logic                    we_i,
  input  logic [7:0]              be_i,
  input  logic [`FRM_ADDR_W-1:0]  addr_i,
  input  framing_pkg::word_t      wdata_i,
  output framing_pkg::word_t      rdata_o,
  buf_port_if.owner               tx_ram_o,
  buf_port_if.owner               rx_ram_o,
  output logic                    tx_start_o,
  output framing_pkg::len_t       tx_len_o,
  input  logic                    tx_busy_i,
  output logic [47:0]             mac_o,
  output logic                    promisc_o,
  output framing_pkg::buf_idx_t   consume_o,
  input  framing_pkg::buf_idx_t   produce_i,
  input  framing_pkg::len_t       rx_len_i [`FRM_RX_BUFS],
  output logic                    irq_o
);
  import framing_pkg::*;

  localparam int REG_SH = `FRM_REG_AW + 3;   // Window sizes as byte address bits
  localparam int TX_SH  = `FRM_TX_AW + 3;
  localparam int RX_SH  = `FRM_RX_AW + 3;

  logic        reg_hit, tx_hit, rx_hit;
  logic        wr_reg;
  reg_idx_e    wr_idx;
  len_t        new_len;
  logic [47:0] mac_q;
  logic        promisc_q;
  logic        irq_en_q;
  len_t        tx_len_q;
  logic        tx_start_q;
  buf_idx_t    consume_q;
  logic        avail;
  logic        rd_reg_q, rd_tx_q, rd_rx_q;
  reg_idx_e    rd_idx_q;
  word_t       reg_rdata;

  assign reg_hit = (addr_i >> REG_SH) == (`FRM_REG_BASE >> REG_SH);
  assign tx_hit  = (addr_i >> TX_SH) == (`FRM_TX_BASE >> TX_SH);
  assign rx_hit  = (addr_i >> RX_SH) == (`FRM_RX_BASE >> RX_SH);

  assign wr_reg  = ce_i & we_i & reg_hit;
  assign wr_idx  = reg_idx_e'(addr_i[REG_SH-1:3]);
  assign new_len = wdata_i[$bits(len_t)-1:0];

  // Buffer windows go straight to port A of each RAM
  assign tx_ram_o.en    = ce_i & tx_hit;
  assign tx_ram_o.we    = we_i ? be_i : 8'h00;
  assign tx_ram_o.addr  = addr_i[TX_SH-1:3];
  assign tx_ram_o.wdata = wdata_i;

  assign rx_ram_o.en    = ce_i & rx_hit;
  assign rx_ram_o.we    = we_i ? be_i : 8'h00;
  assign rx_ram_o.addr  = addr_i[RX_SH-1:3];
  assign rx_ram_o.wdata = wdata_i;

  assign avail = produce_i != consume_q;           // Unread frames in the ring

  always_ff @(posedge clk_int)
  begin
    if (rst_int)
    begin
      mac_q      <= `FRM_DEF_MAC;
      promisc_q  <= 1'b0;
      irq_en_q   <= 1'b0;
      tx_len_q   <= '0;
      tx_start_q <= 1'b0;
      consume_q  <= '0;
      irq_o      <= 1'b0;
    end
    else
    begin
      tx_start_q <= 1'b0;
      irq_o      <= avail & irq_en_q;
      if (wr_reg)
      begin
        case (wr_idx)
          MAC_LO: mac_q[31:0] <= wdata_i[31:0];
          MAC_HI_CTRL:
          begin
            mac_q[47:32] <= wdata_i[15:0];
            promisc_q    <= wdata_i[62];
            irq_en_q     <= wdata_i[63];
          end
          TX_LEN:
          begin
            // Start pulse counts as busy until the framer answers
            if (!tx_busy_i && !tx_start_q && new_len != '0 && new_len <= `FRM_MAX_LEN)
            begin
              tx_len_q   <= new_len;
              tx_start_q <= 1'b1;
            end
          end
          RX_CONSUME: consume_q <= wdata_i[$bits(buf_idx_t)-1:0];
          default: ;
        endcase
      end
    end
  end

  // Read strobe and address are kept for the data phase
  always_ff @(posedge clk_int)
  begin
    if (rst_int)
    begin
      rd_reg_q <= 1'b0;
      rd_tx_q  <= 1'b0;
      rd_rx_q  <= 1'b0;
    end
    else
    begin
      rd_reg_q <= ce_i & ~we_i & reg_hit;
      rd_tx_q  <= ce_i & ~we_i & tx_hit;
      rd_rx_q  <= ce_i & ~we_i & rx_hit;
    end
  end

  always_ff @(posedge clk_int)
  begin
    rd_idx_q <= wr_idx;
  end

  always_comb
  begin
    case (rd_idx_q)
      MAC_LO:      reg_rdata = word_t'(mac_q[31:0]);
      MAC_HI_CTRL: reg_rdata = {irq_en_q, promisc_q, 46'b0, mac_q[47:32]};
      TX_LEN:      reg_rdata = word_t'(tx_len_q);
      RX_STATUS:   reg_rdata = word_t'({tx_busy_i, avail, produce_i, consume_q});
      RX_CONSUME:  reg_rdata = word_t'(consume_q);
      RX_LEN0, RX_LEN1, RX_LEN2, RX_LEN3,
      RX_LEN4, RX_LEN5, RX_LEN6, RX_LEN7:
        reg_rdata = word_t'(rx_len_i[rd_idx_q[2:0]]);
      default:     reg_rdata = '0;
    endcase
  end

  always_comb
  begin
    if (rd_reg_q)
      rdata_o = reg_rdata;
    else if (rd_tx_q)
      rdata_o = tx_ram_o.rdata;
    else if (rd_rx_q)
      rdata_o = rx_ram_o.rdata;
    else
      rdata_o = '0;                                // Missed every window
  end

  assign tx_start_o = tx_start_q;
  assign tx_len_o   = tx_len_q;
  assign mac_o      = mac_q;
  assign promisc_o  = promisc_q;
  assign consume_o  = consume_q;

endmodule

// ==== logic/framing_top.sv ====
// Module framing_top joining the registers, both framers and both buffer RAMs
`include "framing_macros.svh"

module framing_top (
  input  logic                   clk_int,
  input  logic                   rst_int,
  input  logic                   ce_i,
  input  logic                   we_i,
  input  logic [7:0]             be_i,
  input  logic [`FRM_ADDR_W-1:0] addr_i,
  input  framing_pkg::word_t     wdata_i,
  output framing_pkg::word_t     rdata_o,
  output logic [7:0]             tx_data_o,
  output logic                   tx_valid_o,
  input  logic                   tx_ready_i,
  output logic                   tx_last_o,
  input  logic [7:0]             rx_data_i,
  input  logic                   rx_valid_i,
  input  logic                   rx_last_i,
  output logic                   irq_o
);
  import framing_pkg::*;

  logic        tx_start;
  len_t        tx_len;
  logic        tx_busy;
  logic [47:0] mac;
  logic        promisc;
  buf_idx_t    consume;
  buf_idx_t    produce;
  len_t        rx_len [`FRM_RX_BUFS];

  buf_port_if #(.AW(`FRM_TX_AW)) tx_a_if ();     // Bus side
  buf_port_if #(.AW(`FRM_TX_AW)) tx_b_if ();     // Framer side
  buf_port_if #(.AW(`FRM_RX_AW)) rx_a_if ();
  buf_port_if #(.AW(`FRM_RX_AW)) rx_b_if ();

  framing_regs u_regs (
    .clk_int    (clk_int),
    .rst_int    (rst_int),
    .ce_i       (ce_i),
    .we_i       (we_i),
    .be_i       (be_i),
    .addr_i     (addr_i),
    .wdata_i    (wdata_i),
    .rdata_o    (rdata_o),
    .tx_ram_o   (tx_a_if),
    .rx_ram_o   (rx_a_if),
    .tx_start_o (tx_start),
    .tx_len_o   (tx_len),
    .tx_busy_i  (tx_busy),
    .mac_o      (mac),
    .promisc_o  (promisc),
    .consume_o  (consume),
    .produce_i  (produce),
    .rx_len_i   (rx_len),
    .irq_o      (irq_o)
  );

  tx_framer u_tx_framer (
    .clk_int    (clk_int),
    .rst_int    (rst_int),
    .start_i    (tx_start),
    .len_i      (tx_len),
    .busy_o     (tx_busy),
    .ram_o      (tx_b_if),
    .tx_data_o  (tx_data_o),
    .tx_valid_o (tx_valid_o),
    .tx_last_o  (tx_last_o),
    .tx_ready_i (tx_ready_i)
  );

  rx_framer u_rx_framer (
    .clk_int    (clk_int),
    .rst_int    (rst_int),
    .rx_data_i  (rx_data_i),
    .rx_valid_i (rx_valid_i),
    .rx_last_i  (rx_last_i),
    .mac_i      (mac),
    .promisc_i  (promisc),
    .consume_i  (consume),
    .produce_o  (produce),
    .len_o      (rx_len),
    .ram_o      (rx_b_if)
  );

  frame_ram #(.DEPTH_WORDS(`FRM_TX_WORDS)) u_tx_ram (
    .clk_int  (clk_int),
    .rst_int  (rst_int),
    .port_a_i (tx_a_if),
    .port_b_i (tx_b_if)
  );

  frame_ram #(.DEPTH_WORDS(`FRM_RX_BUFS * `FRM_RX_BUF_WORDS)) u_rx_ram (
    .clk_int  (clk_int),
    .rst_int  (rst_int),
    .port_a_i (rx_a_if),
    .port_b_i (rx_b_if)
  );

endmodule

// ==== logic/rx_framer.sv ====
// Module rx_framer that fills the receive ring, filters on destination and keeps pointers
`include "framing_macros.svh"

module rx_framer (
  input  logic                  clk_int,
  input  logic                  rst_int,
  input  logic [7:0]            rx_data_i,
  input  logic                  rx_valid_i,
  input  logic                  rx_last_i,
  input  logic [47:0]           mac_i,
  input  logic                  promisc_i,
  input  framing_pkg::buf_idx_t consume_i,
  output framing_pkg::buf_idx_t produce_o,
  output framing_pkg::len_t     len_o [`FRM_RX_BUFS],
  buf_port_if.owner             ram_o
);
  import framing_pkg::*;

  localparam int IW = $clog2(`FRM_RX_BUFS);
  localparam int OW = $clog2(`FRM_RX_BUF_WORDS);

  len_t        byte_cnt_q;                   // Offset of the incoming byte
  logic [47:0] dest_q, dest_nxt;
  buf_idx_t    produce_q;
  buf_idx_t    fill;
  logic        drop_q;                       // Ring was full when the frame began
  logic        ring_full, drop, in_range, match, accept;
  len_t        len_q [`FRM_RX_BUFS];

  assign fill      = produce_q - consume_i;
  assign ring_full = fill == buf_idx_t'(`FRM_RX_BUFS);
  assign drop      = (byte_cnt_q == '0) ? ring_full : drop_q;
  assign in_range  = byte_cnt_q < `FRM_MAX_LEN;

  // First wire byte ends up in bits 47:40
  assign dest_nxt = (byte_cnt_q < 6) ? {dest_q[39:0], rx_data_i} : dest_q;

  assign match = promisc_i
               | (dest_nxt == mac_i)
               | (&dest_nxt)                         // Broadcast
               | (dest_nxt[47:24] == 24'h01005E);    // IPv4 multicast

  assign accept = rx_valid_i & rx_last_i & ~drop & in_range & match;

  // A dropped frame never touches the buffer that is still unread
  assign ram_o.en    = rx_valid_i & ~drop & in_range;
  assign ram_o.we    = 8'b1 << byte_cnt_q[2:0];
  assign ram_o.addr  = {produce_q[IW-1:0], byte_cnt_q[OW+2:3]};
  assign ram_o.wdata = {8{rx_data_i}};

  always_ff @(posedge clk_int)
  begin
    if (rst_int)
    begin
      byte_cnt_q <= '0;
      produce_q  <= '0;
      drop_q     <= 1'b0;
    end
    else if (rx_valid_i)
    begin
      if (byte_cnt_q == '0)
        drop_q <= ring_full;
      if (rx_last_i)
      begin
        byte_cnt_q <= '0;
        if (accept)
          produce_q <= produce_q + 1'b1;
      end
      else if (in_range)
        byte_cnt_q <= byte_cnt_q + 1'b1;     // Sticks past the limit so the frame is refused
    end
  end

  always_ff @(posedge clk_int)
  begin
    if (rx_valid_i)
    begin
      dest_q <= dest_nxt;
      if (accept)
        len_q[produce_q[IW-1:0]] <= byte_cnt_q + 1'b1;
    end
  end

  assign produce_o = produce_q;
  assign len_o     = len_q;

endmodule

// ==== logic/tx_framer.sv ====
// Module tx_framer that sends the transmit buffer as a valid/ready/last byte stream
`include "framing_macros.svh"

module tx_framer (
  input  logic              clk_int,
  input  logic              rst_int,
  input  logic              start_i,
  input  framing_pkg::len_t len_i,
  output logic              busy_o,
  buf_port_if.owner         ram_o,
  output logic [7:0]        tx_data_o,
  output logic              tx_valid_o,
  output logic              tx_last_o,
  input  logic              tx_ready_i
);
  import framing_pkg::*;

  localparam int WCW = `FRM_TX_AW + 1;       // Counts up to a full buffer of words

  logic           busy_q;
  len_t           len_q;
  len_t           byte_cnt_q;                // Bytes already transferred
  logic [WCW-1:0] words_q;
  logic [WCW-1:0] req_cnt_q;                 // Words requested so far
  logic           pend_q;                    // Read data arrives this cycle
  logic           cur_vld_q, nxt_vld_q;
  word_t          cur_q, nxt_q;
  logic           fire, last_byte, word_done, cur_free, issue;

  assign fire      = cur_vld_q & tx_ready_i;
  assign last_byte = byte_cnt_q == len_q - 1'b1;
  assign word_done = fire & ((byte_cnt_q[2:0] == 3'd7) | last_byte);
  assign cur_free  = ~cur_vld_q | word_done;

  // At most one word is in flight and it lands in the empty prefetch slot
  assign issue = busy_q & ~pend_q & ~nxt_vld_q & (req_cnt_q != words_q);

  assign ram_o.en    = issue;
  assign ram_o.we    = 8'h00;                // Read-only port
  assign ram_o.addr  = req_cnt_q[`FRM_TX_AW-1:0];
  assign ram_o.wdata = '0;

  always_ff @(posedge clk_int)
  begin
    if (rst_int)
    begin
      busy_q     <= 1'b0;
      len_q      <= '0;
      byte_cnt_q <= '0;
      words_q    <= '0;
      req_cnt_q  <= '0;
      pend_q     <= 1'b0;
      cur_vld_q  <= 1'b0;
      nxt_vld_q  <= 1'b0;
    end
    else if (start_i && !busy_q)
    begin
      busy_q     <= 1'b1;
      len_q      <= len_i;
      byte_cnt_q <= '0;
      words_q    <= WCW'((len_i + 12'd7) >> 3);
      req_cnt_q  <= '0;
      pend_q     <= 1'b0;
      cur_vld_q  <= 1'b0;
      nxt_vld_q  <= 1'b0;
    end
    else
    begin
      pend_q <= issue;
      if (issue)
        req_cnt_q <= req_cnt_q + 1'b1;
      if (fire)
      begin
        byte_cnt_q <= byte_cnt_q + 1'b1;
        if (last_byte)
          busy_q <= 1'b0;
      end
      if (cur_free)
      begin
        cur_vld_q <= nxt_vld_q | pend_q;
        nxt_vld_q <= 1'b0;
      end
      else if (pend_q)
        nxt_vld_q <= 1'b1;                   // Current word still draining
    end
  end

  always_ff @(posedge clk_int)
  begin
    if (cur_free)
    begin
      if (nxt_vld_q)
        cur_q <= nxt_q;
      else if (pend_q)
        cur_q <= ram_o.rdata;
    end
    if (pend_q && !cur_free)
      nxt_q <= ram_o.rdata;
  end

  assign busy_o     = busy_q;
  assign tx_valid_o = cur_vld_q;
  assign tx_last_o  = cur_vld_q & last_byte;
  assign tx_data_o  = cur_q[{byte_cnt_q[2:0], 3'b000} +: 8];   // Lowest lane first

endmodule
